/* run.sh */
#!/usr/bin/env bash
# build and run the register tracer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_reg_tracer -o tb_reg_tracer
output=$(./obj_dir/tb_reg_tracer 2>&1 || true)
echo "$output"
if grep -q "ALL TESTS PASSED" <<< "$output"
then
    exit 0
fi
exit 1

/* sim/reg_tracer_properties.sv */
// concurrent checks on serial line, end pulse, symbol handshake and transmitter ready
`timescale 1ns/1ps
`include "trace_macros.svh"

module reg_tracer_properties
    import trace_pkg::*;
    import uart_pkg::*;
(
    input logic                          clk_in,
    input logic                          reset_in,
    input logic                          txd_i,
    input logic                          trace_end_i,
    input tx_state_t                     tx_state_i,
    input logic                          tx_valid_i,
    input logic                          tx_ready_i,
    input logic                          sym_valid_i,
    input logic                          sym_ready_i,
    input sym_kind_t                     sym_kind_i,
    input logic [`TRACE_NAME_IDX_W-1:0]  sym_name_idx_i,
    input logic [`TRACE_NIB_W-1:0]       sym_nibble_i
);

    // nothing offered, so the line stays idle high
    idle_line_high: assert property (@(posedge clk_in) disable iff (reset_in)
        (tx_state_i == TX_IDLE && !tx_valid_i) |=> txd_i)
        else $error("serial line low while the transmitter is idle");

    end_single_clock: assert property (@(posedge clk_in) disable iff (reset_in)
        trace_end_i |=> !trace_end_i)
        else $error("trace end high on two consecutive clocks");

    // a stalled symbol keeps its content
    sym_held: assert property (@(posedge clk_in) disable iff (reset_in)
        (sym_valid_i && !sym_ready_i) |=>
            ($stable(sym_kind_i) && $stable(sym_name_idx_i) && $stable(sym_nibble_i)))
        else $error("symbol changed while stalled");

    // ready comes back only after the 11 clocks of the accepted frame
    ready_low_in_frame: assert property (@(posedge clk_in) disable iff (reset_in)
        $rose(tx_ready_i) |-> $past(tx_valid_i && tx_ready_i, 12))
        else $error("transmitter ready during a frame");

endmodule

bind reg_tracer reg_tracer_properties props0 (
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .txd_i          (txd_o),
    .trace_end_i    (trace_end_o),
    .tx_state_i     (u_tx.state),
    .tx_valid_i     (tx_valid),
    .tx_ready_i     (tx_ready),
    .sym_valid_i    (sym_bus.valid),
    .sym_ready_i    (sym_bus.ready),
    .sym_kind_i     (sym_bus.kind),
    .sym_name_idx_i (sym_bus.name_idx),
    .sym_nibble_i   (sym_bus.nibble)
);

/* sim/tb_reg_tracer.sv */
// register tracer testbench: random register model, serial decoder, dump checker
`timescale 1ns/1ps
`include "trace_macros.svh"

module tb_reg_tracer;

    localparam int DUMP_LEN     = 254;  // bytes in one dump line
    localparam int STOP_BITS    = 2;
    localparam int BYTE_TIMEOUT = 100;  // clocks to wait for a start bit
    localparam int END_TIMEOUT  = 20;
    localparam logic [31:0] SEED = 32'hf68ad5e0;
    // two name characters per register index, A first
    localparam logic [8*32-1:0] NAMES = "A B C D R0R1R2R3R4D0D1STSKINPCP ";

    logic                         clk_in = 1'b0;
    logic                         reset_in;
    logic                         trace_start;
    logic [`TRACE_NIB_W-1:0]      reg_data;
    logic [`TRACE_REG_SEL_W-1:0]  reg_sel;
    logic [`TRACE_NIB_W-1:0]      nib_sel;
    logic                         trace_end;
    logic                         txd;

    logic [63:0]  reg_file [0:15];          // register model
    logic [7:0]   exp_bytes [0:DUMP_LEN-1];
    int           exp_len;
    logic [31:0]  rng_state;
    int           rx_count;                 // frames decoded in this trace
    int           end_pulses = 0;
    int           end_errors = 0;
    int           mismatch_errors = 0;
    int           frame_errors = 0;
    int           timeout_errors = 0;
    int           other_errors = 0;

    always #4 clk_in = ~clk_in;

    // register file answers in the same cycle
    assign reg_data = reg_file[reg_sel][{nib_sel, 2'b00} +: 4];

    reg_tracer dut0 (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .trace_start_i (trace_start),
        .reg_data_i    (reg_data),
        .reg_sel_o     (reg_sel),
        .nib_sel_o     (nib_sel),
        .trace_end_o   (trace_end),
        .txd_o         (txd)
    );

    // end pulse must follow the last byte of the dump
    always @(negedge clk_in)
    begin
        if (!reset_in && trace_end === 1'b1)
        begin
            end_pulses = end_pulses + 1;
            if (rx_count != DUMP_LEN)
            begin
                $display("trace end pulsed after %0d of %0d bytes", rx_count, DUMP_LEN);
                end_errors = end_errors + 1;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x_in);
        logic [31:0] x;
        x = x_in;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int field_top(input int r);
        case (r)
            9, 10, 12, 14: return 4;    // D0, D1, SK, PC
            11, 13:        return 3;    // ST, IN
            15:            return 0;    // P
            default:       return 15;
        endcase
    endfunction

    function automatic logic [7:0] hex_ascii(input logic [3:0] v);
        if (v < 4'd10)
            return "0" + {4'h0, v};
        return "A" + {4'h0, v} - 8'd10;
    endfunction

    task automatic push_byte(input logic [7:0] b);
        if (exp_len < DUMP_LEN)
            exp_bytes[exp_len] = b;
        exp_len = exp_len + 1;
    endtask

    task automatic fill_registers();
        for (int r = 0; r < 16; r++)
        begin
            rng_state = xorshift32(rng_state);
            reg_file[r][63:32] = rng_state;
            rng_state = xorshift32(rng_state);
            reg_file[r][31:0] = rng_state;
        end
    endtask

    // fields start at PC, wrap through P to A and end at IN
    task automatic build_expected();
        int r;
        exp_len = 0;
        for (int f = 0; f < 16; f++)
        begin
            r = (f + 14) % 16;
            push_byte(NAMES[8*(31-2*r) +: 8]);
            push_byte(NAMES[8*(30-2*r) +: 8]);
            push_byte(":");
            push_byte(" ");
            for (int n = field_top(r); n >= 0; n--)
                push_byte(hex_ascii(reg_file[r][n*4 +: 4]));
            push_byte(" ");
        end
        push_byte(8'h0a);
    endtask

    task automatic receive_byte(input string test_name, output logic [7:0] data,
                                output bit got);
        int waited;
        data   = 8'h00;
        got    = 1'b0;
        waited = 0;
        while (txd !== 1'b0)   // start bit
        begin
            if (waited == BYTE_TIMEOUT)
            begin
                $display("timeout in %s: no start bit within %0d clocks", test_name, waited);
                timeout_errors++;
                return;
            end
            @(negedge clk_in);
            waited++;
        end
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk_in);
            data[i] = txd;      // lsb first
        end
        for (int s = 0; s < STOP_BITS; s++)
        begin
            @(negedge clk_in);
            if (txd !== 1'b1)
            begin
                $display("frame error in %s: stop bit %0d of byte %0d is low",
                         test_name, s, rx_count);
                frame_errors++;
            end
        end
        rx_count++;
        got = 1'b1;
    endtask

    task automatic run_dump(input string test_name, input int pulse_clk);
        logic [7:0] rx_byte;
        bit         got;
        bit         quiet;
        int         waited;
        int         pulses_before;
        fill_registers();
        build_expected();
        rx_count      = 0;
        pulses_before = end_pulses;
        trace_start   = 1'b1;
        @(negedge clk_in);
        trace_start = 1'b0;
        fork
            begin
                got = 1'b1;
                for (int i = 0; i < DUMP_LEN && got; i++)
                begin
                    receive_byte(test_name, rx_byte, got);
                    if (got && rx_byte !== exp_bytes[i])
                    begin
                        $display("MISMATCH %s byte %0d: expected %02h actual %02h",
                                 test_name, i, exp_bytes[i], rx_byte);
                        mismatch_errors++;
                    end
                end
            end
            begin
                if (pulse_clk > 0) // start again in the middle of the dump
                begin
                    repeat (pulse_clk) @(negedge clk_in);
                    trace_start = 1'b1;
                    @(negedge clk_in);
                    trace_start = 1'b0;
                end
            end
        join
        if (rx_count != DUMP_LEN)
            return;
        waited = 0;
        while (trace_end !== 1'b1 && waited < END_TIMEOUT)
        begin
            @(negedge clk_in);
            waited++;
        end
        if (trace_end !== 1'b1)
        begin
            $display("timeout in %s: no trace end pulse after the last byte", test_name);
            timeout_errors++;
            return;
        end
        if (waited != 1)   // pulse belongs in the clock after the last stop bit
        begin
            $display("trace end in %s came %0d clocks after the last stop bit, not 1",
                     test_name, waited);
            end_errors++;
        end
        quiet = 1'b1;
        repeat (30)
        begin
            @(negedge clk_in);
            if (txd !== 1'b1)
                quiet = 1'b0;
        end
        if (!quiet)
        begin
            $display("serial line active again after the end of %s", test_name);
            other_errors++;
        end
        if (end_pulses - pulses_before != 1)
        begin
            $display("trace end pulsed %0d times in %s", end_pulses - pulses_before, test_name);
            other_errors++;
        end
    endtask

    initial
    begin
        reset_in    = 1'b1;
        trace_start = 1'b0;
        rng_state   = SEED;
        rx_count    = 0;
        for (int r = 0; r < 16; r++)
            reg_file[r] = 64'h0;
        repeat (8) @(negedge clk_in);
        reset_in = 1'b0;
        for (int c = 0; c < 20; c++)   // idle line after reset
        begin
            @(negedge clk_in);
            if (txd !== 1'b1 || trace_end !== 1'b0)
            begin
                $display("MISMATCH idle_after_reset cycle %0d: expected txd 1 end 0 actual txd %b end %b",
                         c, txd, trace_end);
                mismatch_errors++;
            end
        end
        run_dump("dump_first", 0);
        run_dump("restart_ignored", 1200);
        run_dump("dump_second", 0);
        $display("errors: mismatch %0d, frame %0d, timeout %0d, end pulse %0d, other %0d",
                 mismatch_errors, frame_errors, timeout_errors, end_errors, other_errors);
        if (mismatch_errors + frame_errors + timeout_errors + end_errors + other_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+src
src/trace_pkg.sv
src/uart_pkg.sv
src/trace_sym_if.sv
src/trace_sequencer.sv
src/trace_formatter.sv
src/uart_tx.sv
src/reg_tracer.sv
sim/reg_tracer_properties.sv
sim/tb_reg_tracer.sv

/* src/reg_tracer.sv */
// register tracer top level: sequencer, formatter and serial transmitter
`timescale 1ns/1ps
`include "trace_macros.svh"

module reg_tracer (
    input  logic                         clk_in,
    input  logic                         reset_in,
    input  logic                         trace_start_i,
    input  logic [`TRACE_NIB_W-1:0]      reg_data_i,    // answers in the same cycle
    output logic [`TRACE_REG_SEL_W-1:0]  reg_sel_o,
    output logic [`TRACE_NIB_W-1:0]      nib_sel_o,
    output logic                         trace_end_o,
    output logic                         txd_o
);

    logic       tx_valid;
    logic [7:0] tx_data;
    logic       tx_ready;
    logic       line_done;

    trace_sym_if sym_bus ();

    trace_sequencer u_seq (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .trace_start_i (trace_start_i),
        .sym           (sym_bus.seq),
        .line_done_i   (line_done),
        .trace_end_o   (trace_end_o)
    );

    trace_formatter u_fmt (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .sym           (sym_bus.fmt),
        .reg_data_i    (reg_data_i),
        .tx_ready_i    (tx_ready),
        .reg_sel_o     (reg_sel_o),
        .nib_sel_o     (nib_sel_o),
        .tx_valid_o    (tx_valid),
        .tx_data_o     (tx_data),
        .line_done_o   (line_done)
    );

    uart_tx u_tx (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .tx_valid_i    (tx_valid),
        .tx_data_i     (tx_data),
        .tx_ready_o    (tx_ready),
        .txd_o         (txd_o)
    );

endmodule

/* src/trace_formatter.sv */
// trace formatter: name table, register read, hex conversion, output byte buffer
`timescale 1ns/1ps
`include "trace_macros.svh"

module trace_formatter
    import trace_pkg::*;
(
    input  logic                         clk_in,
    input  logic                         reset_in,
    trace_sym_if.fmt                     sym,
    input  logic [`TRACE_NIB_W-1:0]      reg_data_i,
    input  logic                         tx_ready_i,
    output logic [`TRACE_REG_SEL_W-1:0]  reg_sel_o,
    output logic [`TRACE_NIB_W-1:0]      nib_sel_o,
    output logic                         tx_valid_o,
    output logic [7:0]                   tx_data_o,
    output logic                         line_done_o
);

    logic       buf_valid;
    logic       buf_lf;     // buffered byte is the line feed
    logic [7:0] buf_data;
    logic       lf_busy;    // line feed frame on the wire
    logic       accept;
    logic       tx_xfer;
    logic [7:0] name_char;
    logic [7:0] hex_char;
    logic [7:0] sym_char;

    // register read follows the offered symbol
    assign reg_sel_o = sym.name_idx[`TRACE_NAME_IDX_W-1:1];
    assign nib_sel_o = sym.nibble;

    assign tx_xfer   = buf_valid & tx_ready_i;
    assign sym.ready = ~buf_valid | tx_ready_i; // empty or draining now
    assign accept    = sym.valid & sym.ready;

    assign tx_valid_o  = buf_valid;
    assign tx_data_o   = buf_data;
    assign line_done_o = lf_busy & tx_ready_i;

    assign hex_char = (reg_data_i > 4'h9) ? (8'd55 + {4'h0, reg_data_i})
                                          : (8'h30 + {4'h0, reg_data_i});

    always_comb
    begin
        case (sym.name_idx)
            5'h00: name_char = "A";
            5'h01: name_char = " ";
            5'h02: name_char = "B";
            5'h03: name_char = " ";
            5'h04: name_char = "C";
            5'h05: name_char = " ";
            5'h06: name_char = "D";
            5'h07: name_char = " ";
            5'h08: name_char = "R";
            5'h09: name_char = "0";
            5'h0a: name_char = "R";
            5'h0b: name_char = "1";
            5'h0c: name_char = "R";
            5'h0d: name_char = "2";
            5'h0e: name_char = "R";
            5'h0f: name_char = "3";
            5'h10: name_char = "R";
            5'h11: name_char = "4";
            5'h12: name_char = "D";
            5'h13: name_char = "0";
            5'h14: name_char = "D";
            5'h15: name_char = "1";
            5'h16: name_char = "S";
            5'h17: name_char = "T";
            5'h18: name_char = "S";
            5'h19: name_char = "K";
            5'h1a: name_char = "I";
            5'h1b: name_char = "N";
            5'h1c: name_char = "P";
            5'h1d: name_char = "C";
            5'h1e: name_char = "P";
            default: name_char = " ";
        endcase
    end

    always_comb
    begin
        case (sym.kind)
            SYM_NAME:  sym_char = name_char;
            SYM_COLON: sym_char = ":";
            SYM_HEX:   sym_char = hex_char;
            SYM_LF:    sym_char = 8'h0a;
            default:   sym_char = " ";
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            buf_valid <= 1'b0;
            buf_lf    <= 1'b0;
            lf_busy   <= 1'b0;
        end
        else
        begin
            if (accept)
            begin
                buf_valid <= 1'b1;
                buf_lf    <= (sym.kind == SYM_LF);
            end
            else if (tx_xfer)
                buf_valid <= 1'b0;

            if (tx_xfer & buf_lf)
                lf_busy <= 1'b1;
            else if (line_done_o)
                lf_busy <= 1'b0; // transmitter back to idle
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept)
            buf_data <= sym_char;
    end

endmodule

/* src/trace_macros.svh */
// tracer widths, dump start and end positions, serial stop-bit count
`ifndef TRACE_MACROS_SVH
`define TRACE_MACROS_SVH

// register file read port
`define TRACE_NIB_W       4     // one data nibble
`define TRACE_REG_SEL_W   4     // register index, 16 fields

// name table
`define TRACE_NAME_IDX_W  5     // two characters per field
`define TRACE_FIRST_NAME  5'h1c // PC name, dump starts here
`define TRACE_LAST_NAME   5'h1b // second char of IN, last field

// serial frame
`define UART_STOP_BITS    2     // high bits after the data byte

`endif

/* src/trace_pkg.sv */
// symbol kinds and sequencer states for the register tracer
package trace_pkg;

    // which character the formatter has to produce
    typedef enum logic [2:0] {
        SYM_NAME,   // letter from the name table
        SYM_COLON,
        SYM_SPACE,
        SYM_HEX,    // register nibble as hex digit
        SYM_LF      // end of the dump line
    } sym_kind_t;

    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_NAME0,  // first name char
        SEQ_NAME1,  // second name char
        SEQ_COLON,
        SEQ_SPACE,
        SEQ_NIB,    // nibbles, top one down to 0
        SEQ_TRAIL,  // space after the value
        SEQ_NEXT,   // step to next field or finish
        SEQ_LF,
        SEQ_DONE    // wait for the line feed to leave the wire
    } seq_state_t;

endpackage

/* src/trace_sequencer.sv */
// trace sequencer: walks fields and nibbles, issues one symbol per transfer
`timescale 1ns/1ps
`include "trace_macros.svh"

module trace_sequencer
    import trace_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset_in,
    input  logic        trace_start_i,
    trace_sym_if.seq    sym,
    input  logic        line_done_i,   // line feed has left the wire
    output logic        trace_end_o
);

    seq_state_t                    state;
    logic [`TRACE_NAME_IDX_W-1:0]  name_pos;  // current name position
    logic [`TRACE_NIB_W-1:0]       nib_cnt;   // nibble being sent
    logic [`TRACE_NIB_W-1:0]       field_top; // top nibble of current field
    logic                          xfer;

    assign xfer = sym.valid & sym.ready;

    // top nibble per register index
    always_comb
    begin
        case (name_pos[`TRACE_NAME_IDX_W-1:1])
            4'h9:    field_top = 4'h4; // D0
            4'ha:    field_top = 4'h4; // D1
            4'hb:    field_top = 4'h3; // ST
            4'hc:    field_top = 4'h4; // SK
            4'hd:    field_top = 4'h3; // IN, 16 bits
            4'he:    field_top = 4'h4; // PC
            4'hf:    field_top = 4'h0; // P
            default: field_top = 4'hf; // A to D, R0 to R4
        endcase
    end

    always_comb
    begin
        sym.valid = 1'b1;
        sym.kind  = SYM_SPACE;
        case (state)
            SEQ_NAME0: sym.kind = SYM_NAME;
            SEQ_NAME1: sym.kind = SYM_NAME;
            SEQ_COLON: sym.kind = SYM_COLON;
            SEQ_NIB:   sym.kind = SYM_HEX;
            SEQ_LF:    sym.kind = SYM_LF;
            SEQ_SPACE,
            SEQ_TRAIL: sym.kind = SYM_SPACE;
            default:   sym.valid = 1'b0; // idle, next, done
        endcase
    end

    assign sym.name_idx = name_pos;
    assign sym.nibble   = nib_cnt;

    assign trace_end_o = (state == SEQ_DONE) & line_done_i;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            state    <= SEQ_IDLE;
            name_pos <= `TRACE_FIRST_NAME;
            nib_cnt  <= '0;
        end
        else
        begin
            case (state)
                SEQ_IDLE:
                    if (trace_start_i)
                    begin
                        name_pos <= `TRACE_FIRST_NAME;
                        state    <= SEQ_NAME0;
                    end
                SEQ_NAME0:
                    if (xfer)
                    begin
                        name_pos <= name_pos + 1'b1;
                        state    <= SEQ_NAME1;
                    end
                SEQ_NAME1:
                    if (xfer)
                        state <= SEQ_COLON;
                SEQ_COLON:
                    if (xfer)
                        state <= SEQ_SPACE;
                SEQ_SPACE:
                    if (xfer)
                    begin
                        nib_cnt <= field_top;
                        state   <= SEQ_NIB;
                    end
                SEQ_NIB:
                    if (xfer)
                    begin
                        if (nib_cnt == '0)
                            state <= SEQ_TRAIL;
                        else
                            nib_cnt <= nib_cnt - 1'b1;
                    end
                SEQ_TRAIL:
                    if (xfer)
                        state <= SEQ_NEXT;
                SEQ_NEXT:
                    if (name_pos == `TRACE_LAST_NAME)
                        state <= SEQ_LF;
                    else
                    begin
                        name_pos <= name_pos + 1'b1; // wraps from P to A
                        state    <= SEQ_NAME0;
                    end
                SEQ_LF:
                    if (xfer)
                        state <= SEQ_DONE;
                SEQ_DONE:
                    if (line_done_i)
                        state <= SEQ_IDLE;
                default:
                    state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

/* src/trace_sym_if.sv */
// symbol handshake between the trace sequencer and the formatter
`timescale 1ns/1ps
`include "trace_macros.svh"

interface trace_sym_if
    import trace_pkg::*;
();

    logic                          valid;    // symbol offered
    sym_kind_t                     kind;
    logic [`TRACE_NAME_IDX_W-1:0]  name_idx; // name position, index is idx/2
    logic [`TRACE_NIB_W-1:0]       nibble;   // nibble for hex symbols
    logic                          ready;    // formatter can take it

    modport seq (
        output valid, kind, name_idx, nibble,
        input  ready
    );

    modport fmt (
        input  valid, kind, name_idx, nibble,
        output ready
    );

endinterface

/* src/uart_pkg.sv */
// serial transmitter state encoding
package uart_pkg;

    typedef enum logic [1:0] {
        TX_IDLE,    // line high, ready for a byte
        TX_START,   // low start bit
        TX_DATA,    // eight data bits, lsb first
        TX_STOP     // high stop bits
    } tx_state_t;

endpackage

/* src/uart_tx.sv */
// serial transmitter, one bit per clock: start, 8 data bits lsb first, stop bits
`timescale 1ns/1ps
`include "trace_macros.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset_in,
    input  logic        tx_valid_i,
    input  logic [7:0]  tx_data_i,
    output logic        tx_ready_o,
    output logic        txd_o
);

    tx_state_t   state;
    logic [7:0]  shift;     // data bits, lsb goes out first
    logic [2:0]  bit_cnt;
    logic [1:0]  stop_cnt;

    assign tx_ready_o = (state == TX_IDLE);

    always_comb
    begin
        case (state)
            TX_START: txd_o = 1'b0;
            TX_DATA:  txd_o = shift[0];
            default:  txd_o = 1'b1; // idle and stop bits
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            state    <= TX_IDLE;
            bit_cnt  <= '0;
            stop_cnt <= '0;
        end
        else
        begin
            case (state)
                TX_IDLE:
                    if (tx_valid_i)
                        state <= TX_START;
                TX_START:
                begin
                    bit_cnt <= '0;
                    state   <= TX_DATA;
                end
                TX_DATA:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7)
                    begin
                        stop_cnt <= '0;
                        state    <= TX_STOP;
                    end
                end
                TX_STOP:
                begin
                    stop_cnt <= stop_cnt + 1'b1;
                    if (stop_cnt == 2'(`UART_STOP_BITS - 1))
                        state <= TX_IDLE;
                end
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (tx_ready_o & tx_valid_i)
            shift <= tx_data_i;
        else if (state == TX_DATA)
            shift <= shift >> 1;
    end

endmodule
